//--- source/rvic_irq_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interrupt-side constants and types for the rvic
// interrupt controller, shared by the gateway, the
// arbiter and the register block
// refer to members as rvic_irq_pkg::name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rvic_irq_pkg;

    // number of interrupt source lines
    localparam int NUM_SRC = 32;

    // a source identity is wide enough for NUM_SRC with room to spare
    localparam int ID_W = 8;

    // each source gets one full byte of priority
    localparam int PRIO_W = 8;

    // one bit per source, bit i belongs to source i
    typedef logic [NUM_SRC-1:0] src_vec_t;

    // identity of a source as reported on irq_id_o
    typedef logic [ID_W-1:0] irq_id_t;

    // priority of one source, zero means the source can never win
    typedef logic [PRIO_W-1:0] prio_t;

    // all priorities, element i belongs to source i
    typedef prio_t [NUM_SRC-1:0] prio_arr_t;

endpackage

//--- source/rvic_reg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map and bus types of the rvic register
// interface, used by the top level and the register
// block, refer to members as rvic_reg_pkg::name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rvic_reg_pkg;

    // one data word on the register bus
    typedef logic [31:0] reg_word_t;

    // one enable bit per byte lane of a data word
    typedef logic [3:0] reg_be_t;

    // local offset once the base address has been removed
    typedef logic [15:0] reg_addr_t;

    // per-source enable word
    localparam reg_addr_t ADDR_ENABLE = 16'h0000;

    // pending word, a write of 1 clears the bit
    localparam reg_addr_t ADDR_PENDING = 16'h0004;

    // first priority word, the rest follow every 4 bytes up to 0x24
    localparam reg_addr_t ADDR_PRIO_BASE = 16'h0008;

    // four priorities per word gives eight words for 32 sources
    localparam int NUM_PRIO_REGS = 8;

endpackage

//--- source/rvic_reg_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// internal register access bus between the top level
// and the register block
// strobes last one cycle, read data is combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface rvic_reg_if;

    logic                   re;
    logic                   we;
    rvic_reg_pkg::reg_addr_t addr;
    rvic_reg_pkg::reg_word_t wdata;
    rvic_reg_pkg::reg_be_t   be;
    rvic_reg_pkg::reg_word_t rdata;

    // the top level issues requests and samples the read word
    modport master (output re, we, addr, wdata, be, input rdata);

    // the register block decodes requests and returns the read word
    modport slave (input re, we, addr, wdata, be, output rdata);

endinterface

//--- source/rvic_irq_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interrupt state shared by the register block, the
// edge gateway and the arbiter inside rvic_core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface rvic_irq_if;

    rvic_irq_pkg::src_vec_t  enable;
    rvic_irq_pkg::src_vec_t  pending;
    rvic_irq_pkg::prio_arr_t prio;
    // bits to clear in the pending word, only valid with clr_strobe
    rvic_irq_pkg::src_vec_t  clr_mask;
    logic                    clr_strobe;

    // register block owns enable, priorities and the clear request
    modport regs (output enable, prio, clr_mask, clr_strobe, input pending);

    // gateway owns the pending word
    modport gateway (input clr_mask, clr_strobe, output pending);

    // arbiter only looks at the state
    modport arbiter (input enable, pending, prio);

endinterface

//--- source/rvic_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register block of the rvic: offset decode, enable
// and priority storage with byte enables, the
// write-1-to-clear request for pending bits and the
// combinational read mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rvic_regs (
    input  logic        clk_i,
    input  logic        reset_i,
    rvic_reg_if.slave   reg_bus,
    rvic_irq_if.regs    irq_bus
);

    localparam int PRIO_IDX_W = $clog2(rvic_reg_pkg::NUM_PRIO_REGS);

    rvic_irq_pkg::src_vec_t  enable_q;
    rvic_irq_pkg::prio_arr_t prio_q;
    rvic_reg_pkg::reg_word_t be_mask;
    rvic_reg_pkg::reg_addr_t prio_off;
    logic [PRIO_IDX_W-1:0]   prio_idx;
    logic                    hit_enable;
    logic                    hit_pending;
    logic                    hit_prio;

    // each byte enable widens to a full byte of mask
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            be_mask[8*b +: 8] = {8{reg_bus.be[b]}};
        end
    end

    assign hit_enable  = (reg_bus.addr == rvic_reg_pkg::ADDR_ENABLE);
    assign hit_pending = (reg_bus.addr == rvic_reg_pkg::ADDR_PENDING);

    // priority words sit word aligned from the base up to 0x24
    assign prio_off = reg_bus.addr - rvic_reg_pkg::ADDR_PRIO_BASE;
    assign prio_idx = prio_off[PRIO_IDX_W+1:2];
    assign hit_prio = (reg_bus.addr >= rvic_reg_pkg::ADDR_PRIO_BASE) &&
                      (prio_off < rvic_reg_pkg::reg_addr_t'(4 * rvic_reg_pkg::NUM_PRIO_REGS)) &&
                      (reg_bus.addr[1:0] == 2'b00);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q <= '0;
            prio_q   <= '0;
        end else if (reg_bus.we) begin
            if (hit_enable) begin
                enable_q <= (enable_q & ~be_mask) | (reg_bus.wdata & be_mask);
            end
            // byte b of priority word i is the priority of source 4*i+b
            if (hit_prio) begin
                for (int b = 0; b < 4; b++) begin
                    if (reg_bus.be[b]) begin
                        prio_q[4*prio_idx + b] <= reg_bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // the gateway applies the clear in the same edge as the write
    assign irq_bus.clr_strobe = reg_bus.we & hit_pending;
    assign irq_bus.clr_mask   = reg_bus.wdata & be_mask;

    assign irq_bus.enable = enable_q;
    assign irq_bus.prio   = prio_q;

    // unmapped offsets read as zero
    always_comb begin
        reg_bus.rdata = '0;
        if (hit_enable) begin
            reg_bus.rdata = enable_q;
        end else if (hit_pending) begin
            reg_bus.rdata = irq_bus.pending;
        end else if (hit_prio) begin
            reg_bus.rdata = prio_q[4*prio_idx +: 4];
        end
    end

endmodule

//--- source/rvic_gateway.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// edge gateway of the rvic: samples the source lines,
// detects rising edges and keeps the pending word
// a new edge beats a software clear of the same bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rvic_gateway (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  rvic_irq_pkg::src_vec_t src_i,
    rvic_irq_if.gateway            irq_bus
);

    rvic_irq_pkg::src_vec_t src_q;
    rvic_irq_pkg::src_vec_t src_prev;
    rvic_irq_pkg::src_vec_t rise;
    rvic_irq_pkg::src_vec_t clr;
    rvic_irq_pkg::src_vec_t pending_q;

    // src_q is the sample, src_prev the sample one edge older
    assign rise = src_q & ~src_prev;

    // the clear mask only counts in the cycle of a pending write
    assign clr = irq_bus.clr_strobe ? irq_bus.clr_mask : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            src_q     <= '0;
            src_prev  <= '0;
            pending_q <= '0;
        end else begin
            src_q     <= src_i;
            src_prev  <= src_q;
            // or-ing the edge in last lets the set win over the clear
            pending_q <= (pending_q & ~clr) | rise;
        end
    end

    assign irq_bus.pending = pending_q;

endmodule

//--- source/rvic_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// priority arbiter of the rvic: picks the enabled,
// pending source with the highest nonzero priority,
// lower index on a tie, and registers the request
// flag and the winning identity
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rvic_arbiter (
    input  logic                  clk_i,
    input  logic                  reset_i,
    rvic_irq_if.arbiter           irq_bus,
    output logic                  irq_o,
    output rvic_irq_pkg::irq_id_t irq_id_o
);

    localparam int NODES = 2 * rvic_irq_pkg::NUM_SRC;

    // heap layout, node n has children 2n and 2n+1, leaves start at NUM_SRC
    rvic_irq_pkg::prio_t   node_prio [1:NODES-1];
    rvic_irq_pkg::irq_id_t node_id   [1:NODES-1];
    logic                  win_vld;

    always_comb begin
        // an ineligible source enters the tree with priority zero
        for (int i = 0; i < rvic_irq_pkg::NUM_SRC; i++) begin
            node_id[rvic_irq_pkg::NUM_SRC + i] = rvic_irq_pkg::irq_id_t'(i);
            if (irq_bus.enable[i] && irq_bus.pending[i]) begin
                node_prio[rvic_irq_pkg::NUM_SRC + i] = irq_bus.prio[i];
            end else begin
                node_prio[rvic_irq_pkg::NUM_SRC + i] = '0;
            end
        end
        // the right child only wins when strictly higher, so ties go left
        for (int n = rvic_irq_pkg::NUM_SRC - 1; n >= 1; n--) begin
            if (node_prio[2*n+1] > node_prio[2*n]) begin
                node_prio[n] = node_prio[2*n+1];
                node_id[n]   = node_id[2*n+1];
            end else begin
                node_prio[n] = node_prio[2*n];
                node_id[n]   = node_id[2*n];
            end
        end
    end

    // a zero root priority means nothing is eligible
    assign win_vld = (node_prio[1] != '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_o    <= 1'b0;
            irq_id_o <= '0;
        end else begin
            irq_o    <= win_vld;
            irq_id_o <= win_vld ? node_id[1] : '0;
        end
    end

endmodule

//--- source/rvic_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core of the rvic: the register block, the edge
// gateway and the arbiter joined by the interrupt
// state interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rvic_core (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  rvic_irq_pkg::src_vec_t src_i,
    output logic                   irq_o,
    output rvic_irq_pkg::irq_id_t  irq_id_o,
    rvic_reg_if.slave              reg_bus
);

    rvic_irq_if irq_bus ();

    rvic_regs u_regs (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .reg_bus (reg_bus),
        .irq_bus (irq_bus.regs)
    );

    rvic_gateway u_gateway (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .src_i   (src_i),
        .irq_bus (irq_bus.gateway)
    );

    rvic_arbiter u_arbiter (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .irq_bus  (irq_bus.arbiter),
        .irq_o    (irq_o),
        .irq_id_o (irq_id_o)
    );

endmodule

//--- source/rvic_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the rvic interrupt controller with an
// OBI style register bus: a one-cycle request, no
// acknowledge, read data on data_o one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rvic_top (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  rvic_irq_pkg::src_vec_t  src_i,
    output logic                    irq_o,
    output rvic_irq_pkg::irq_id_t   irq_id_o,
    input  logic                    req_i,
    input  logic                    we_i,
    input  rvic_reg_pkg::reg_be_t   be_i,
    input  logic [31:0]             addr_i,
    input  rvic_reg_pkg::reg_word_t data_i,
    output rvic_reg_pkg::reg_word_t data_o
);

    rvic_reg_if reg_bus ();

    // a request is either a read or a write for exactly one cycle
    assign reg_bus.re    = req_i & ~we_i;
    assign reg_bus.we    = req_i & we_i;
    // the base address is decoded outside, only the offset matters here
    assign reg_bus.addr  = addr_i[15:0];
    assign reg_bus.wdata = data_i;
    assign reg_bus.be    = be_i;

    rvic_core u_core (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .src_i    (src_i),
        .irq_o    (irq_o),
        .irq_id_o (irq_id_o),
        .reg_bus  (reg_bus.slave)
    );

    // data_o keeps the last read word until the next read request
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            data_o <= '0;
        end else if (reg_bus.re) begin
            data_o <= reg_bus.rdata;
        end
    end

endmodule

//--- sim/rvic_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assertions on the rvic arbiter outputs, bound to
// every rvic_arbiter instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rvic_chk (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   irq_i,
    input rvic_irq_pkg::irq_id_t  irq_id_i,
    input rvic_irq_pkg::src_vec_t enable_i,
    input rvic_irq_pkg::src_vec_t pending_i
);

    rvic_irq_pkg::src_vec_t eligible_q;
    int unsigned            fail_cnt = 0;

    // the state the arbiter saw at the edge that loaded irq_i
    always_ff @(posedge clk_i) begin
        eligible_q <= enable_i & pending_i;
    end

    // the output register was cleared by the reset edge before
    assert property (@(posedge clk_i) $past(reset_i) |-> !irq_i)
        else begin
            fail_cnt++;
            $error("irq_o is set in the cycle after reset");
        end

    // 32 sources, so the low five bits of the identity index the vector
    assert property (@(posedge clk_i) disable iff (reset_i)
                     irq_i |-> (irq_id_i < rvic_irq_pkg::NUM_SRC) && eligible_q[irq_id_i[4:0]])
        else begin
            fail_cnt++;
            $error("irq_id_o names a source that was not enabled and pending");
        end

    assert property (@(posedge clk_i) !irq_i |-> (irq_id_i == '0))
        else begin
            fail_cnt++;
            $error("irq_id_o is not zero while irq_o is low");
        end

endmodule

bind rvic_arbiter rvic_chk u_chk (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .irq_i     (irq_o),
    .irq_id_i  (irq_id_o),
    .enable_i  (irq_bus.enable),
    .pending_i (irq_bus.pending)
);

//--- sim/rvic_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the rvic interrupt controller
// drives rvic_top through register access, source
// edges, arbitration and a random sequence, and
// compares irq_o and irq_id_o with a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rvic_tb;

    logic                    clk;
    logic                    reset;
    rvic_irq_pkg::src_vec_t  src;
    logic                    req;
    logic                    we;
    rvic_reg_pkg::reg_be_t   be;
    logic [31:0]             addr;
    rvic_reg_pkg::reg_word_t wdata;
    rvic_reg_pkg::reg_word_t rdata;
    logic                    irq;
    rvic_irq_pkg::irq_id_t   irq_id;

    // register state as software expects to see it
    rvic_irq_pkg::src_vec_t  model_enable;
    rvic_irq_pkg::src_vec_t  model_pending;
    rvic_irq_pkg::prio_arr_t model_prio;

    logic [31:0] lcg_state = 32'd75;
    int          num_checks = 0;
    int          num_errors = 0;
    event        compare_ev;

    rvic_top UUT (
        .clk_i    (clk),
        .reset_i  (reset),
        .src_i    (src),
        .irq_o    (irq),
        .irq_id_o (irq_id),
        .req_i    (req),
        .we_i     (we),
        .be_i     (be),
        .addr_i   (addr),
        .data_i   (wdata),
        .data_o   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // replaces the bytes of old_w that sel picks with those of new_w
    function automatic rvic_reg_pkg::reg_word_t merge_bytes(
        input rvic_reg_pkg::reg_word_t old_w,
        input rvic_reg_pkg::reg_word_t new_w,
        input rvic_reg_pkg::reg_be_t   sel
    );
        rvic_reg_pkg::reg_word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // scanning upwards with a strict compare keeps the lower index on a tie
    function automatic logic ref_arbitrate(
        input  rvic_irq_pkg::src_vec_t  en,
        input  rvic_irq_pkg::src_vec_t  pend,
        input  rvic_irq_pkg::prio_arr_t pr,
        output rvic_irq_pkg::irq_id_t   id
    );
        rvic_irq_pkg::prio_t best;
        best = '0;
        id   = '0;
        for (int i = 0; i < rvic_irq_pkg::NUM_SRC; i++) begin
            if (en[i] && pend[i] && (pr[i] > best)) begin
                best = pr[i];
                id   = rvic_irq_pkg::irq_id_t'(i);
            end
        end
        return best != '0;
    endfunction

    // what a bus write does to the software view of the registers
    function automatic void model_write(
        input logic [31:0]             a,
        input rvic_reg_pkg::reg_word_t d,
        input rvic_reg_pkg::reg_be_t   sel
    );
        int w;
        if (a[15:0] == rvic_reg_pkg::ADDR_ENABLE) begin
            model_enable = merge_bytes(model_enable, d, sel);
        end else if (a[15:0] == rvic_reg_pkg::ADDR_PENDING) begin
            model_pending = model_pending & ~merge_bytes('0, d, sel);
        end else if (a[15:0] >= rvic_reg_pkg::ADDR_PRIO_BASE && a[1:0] == 2'b00 &&
                     a[15:0] < rvic_reg_pkg::ADDR_PRIO_BASE + 4 * rvic_reg_pkg::NUM_PRIO_REGS) begin
            w = (int'(a[15:0]) - int'(rvic_reg_pkg::ADDR_PRIO_BASE)) / 4;
            model_prio[4*w +: 4] = merge_bytes(model_prio[4*w +: 4], d, sel);
        end
    endfunction

    // every task starts and ends 2 ns after a rising edge
    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic reg_write(
        input logic [31:0]             a,
        input rvic_reg_pkg::reg_word_t d,
        input rvic_reg_pkg::reg_be_t   sel
    );
        req   = 1'b1;
        we    = 1'b1;
        addr  = a;
        wdata = d;
        be    = sel;
        tick(1);
        req = 1'b0;
        we  = 1'b0;
        model_write(a, d, sel);
    endtask

    // data_o is loaded at the edge that sees the request
    task automatic reg_read(input logic [31:0] a, output rvic_reg_pkg::reg_word_t d);
        req  = 1'b1;
        we   = 1'b0;
        addr = a;
        tick(1);
        req = 1'b0;
        d   = rdata;
    endtask

    task automatic check_word(
        input string                   name,
        input rvic_reg_pkg::reg_word_t got,
        input rvic_reg_pkg::reg_word_t exp
    );
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_irq(
        input logic                  got_irq,
        input rvic_irq_pkg::irq_id_t got_id,
        input logic                  exp_irq,
        input rvic_irq_pkg::irq_id_t exp_id
    );
        num_checks++;
        if (got_irq !== exp_irq || got_id !== exp_id) begin
            num_errors++;
            $display("FAIL irq_o/irq_id_o got 0x%h/0x%02h expected 0x%h/0x%02h",
                     got_irq, got_id, exp_irq, exp_id);
        end
    endtask

    task automatic read_check(input logic [31:0] a, input rvic_reg_pkg::reg_word_t exp);
        rvic_reg_pkg::reg_word_t rd;
        reg_read(a, rd);
        check_word("data_o", rd, exp);
    endtask

    // a 0 to 1 change on a source line is what sets its pending bit
    task automatic set_source(input int s, input logic v);
        if (v && !src[s]) begin
            model_pending[s] = 1'b1;
        end
        src[s] = v;
    endtask

    // byte s%4 of priority word s/4 holds the priority of source s
    task automatic set_prio(input int s, input rvic_irq_pkg::prio_t p);
        reg_write(rvic_reg_pkg::ADDR_PRIO_BASE + 4 * (s / 4),
                  rvic_reg_pkg::reg_word_t'(p) << (8 * (s % 4)),
                  rvic_reg_pkg::reg_be_t'(1 << (s % 4)));
    endtask

    task automatic wait_irq(input logic exp_irq, input rvic_irq_pkg::irq_id_t exp_id);
        int n;
        n = 0;
        while ((irq !== exp_irq || irq_id !== exp_id) && n < 20) begin
            tick(1);
            n++;
        end
        if (irq !== exp_irq || irq_id !== exp_id) begin
            $display("timeout: irq_o and irq_id_o did not reach %h/0x%02h within 20 cycles",
                     exp_irq, exp_id);
        end
        check_irq(irq, irq_id, exp_irq, exp_id);
        -> compare_ev;
    endtask

    // compares the DUT outputs with the reference model whenever stimulus has settled
    initial begin
        logic                  exp_irq;
        rvic_irq_pkg::irq_id_t exp_id;
        forever begin
            @(compare_ev);
            exp_irq = ref_arbitrate(model_enable, model_pending, model_prio, exp_id);
            check_irq(irq, irq_id, exp_irq, exp_id);
        end
    end

    initial begin
        logic [31:0] r;
        int          s;
        reset         = 1'b1;
        src           = '0;
        req           = 1'b0;
        we            = 1'b0;
        be            = '0;
        addr          = '0;
        wdata         = '0;
        model_enable  = '0;
        model_pending = '0;
        model_prio    = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        tick(1);

        // every mapped word reads zero after reset
        check_irq(irq, irq_id, 1'b0, '0);
        for (int a = 0; a <= 'h24; a += 4) begin
            read_check(a, '0);
        end
        $display("test 1 reset values finished, errors %0d", num_errors);

        // full and partial writes, then offsets that hold no register
        reg_write(rvic_reg_pkg::ADDR_ENABLE, 32'hA5A5_1234, 4'hF);
        read_check(rvic_reg_pkg::ADDR_ENABLE, 32'hA5A5_1234);
        reg_write(rvic_reg_pkg::ADDR_ENABLE, 32'hFFFF_FFFF, 4'b0101);
        read_check(rvic_reg_pkg::ADDR_ENABLE, 32'hA5FF_12FF);
        reg_write(32'h10, 32'h0403_0201, 4'hF);
        read_check(32'h10, 32'h0403_0201);
        reg_write(32'h10, 32'h0000_7700, 4'b0010);
        read_check(32'h10, 32'h0403_7701);
        read_check(32'h28, '0);
        read_check(32'h0A, '0);
        read_check(32'h100, '0);
        reg_write(rvic_reg_pkg::ADDR_ENABLE, '0, 4'hF);
        reg_write(32'h10, '0, 4'hF);
        $display("test 2 register access finished, errors %0d", num_errors);

        // the clear holds while the line stays high, since no new edge arrives
        set_source(5, 1'b1);
        tick(3);
        read_check(rvic_reg_pkg::ADDR_PENDING, 32'h0000_0020);
        reg_write(rvic_reg_pkg::ADDR_PENDING, 32'h0000_0020, 4'hF);
        tick(3);
        read_check(rvic_reg_pkg::ADDR_PENDING, '0);
        set_source(5, 1'b0);
        tick(3);
        read_check(rvic_reg_pkg::ADDR_PENDING, '0);
        $display("test 3 pending edge and clear finished, errors %0d", num_errors);

        // sources 9 and 12 tie at 7, source 20 has priority 0
        set_prio(3, 8'd5);
        set_prio(9, 8'd7);
        set_prio(12, 8'd7);
        set_prio(20, 8'd0);
        reg_write(rvic_reg_pkg::ADDR_ENABLE, 32'hFFFF_FFFF, 4'hF);
        set_source(3, 1'b1);
        set_source(9, 1'b1);
        set_source(12, 1'b1);
        set_source(20, 1'b1);
        wait_irq(1'b1, 8'd9);
        reg_write(rvic_reg_pkg::ADDR_ENABLE, 32'hFFFF_FDFF, 4'hF);
        wait_irq(1'b1, 8'd12);
        set_prio(12, 8'd0);
        wait_irq(1'b1, 8'd3);
        reg_write(rvic_reg_pkg::ADDR_PENDING, 32'h0000_0008, 4'hF);
        wait_irq(1'b0, 8'd0);
        src = '0;
        tick(2);
        $display("test 4 arbitration finished, errors %0d", num_errors);

        // the top two bits choose the operation, three edges let it settle
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            case (r[31:30])
                2'd0: begin
                    s = int'(r[12:8]);
                    set_source(s, !src[s]);
                end
                2'd1: reg_write(rvic_reg_pkg::ADDR_ENABLE, lcg_next(), r[3:0]);
                2'd2: reg_write(rvic_reg_pkg::ADDR_PRIO_BASE + 4 * r[10:8], lcg_next(), r[3:0]);
                default: reg_write(rvic_reg_pkg::ADDR_PENDING, lcg_next() & lcg_next(), 4'hF);
            endcase
            tick(3);
            -> compare_ev;
            // the model must stay still until the compare has read it
            tick(1);
        end
        $display("test 5 random sequence finished, errors %0d", num_errors);

        num_errors += int'(UUT.u_core.u_arbiter.u_chk.fail_cnt);
        $display("checks %0d, errors %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
source/rvic_irq_pkg.sv
source/rvic_reg_pkg.sv
source/rvic_reg_if.sv
source/rvic_irq_if.sv
source/rvic_regs.sv
source/rvic_gateway.sv
source/rvic_arbiter.sv
source/rvic_core.sv
source/rvic_top.sv
sim/rvic_chk.sv
sim/rvic_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the rvic testbench

TOP := rvic_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
